//--- logic/gpio_pkg.sv
// widths, types and register offsets shared by the gpio rtl blocks and the testbench
package gpio_pkg;

  ////////////////////
  // widths
  ////////////////////

  // number of pins, also the width of every mask
  localparam int GPIO_W = 32;

  // synchronizer flops per pin
  localparam int CDC_STAGES = 2;

  // byte address covers seven word registers
  localparam int ADR_W = 5;
  localparam int DAT_W = 32;

  // sample period minus one
  localparam int PRE_W = 16;

  ////////////////////
  // types
  ////////////////////

  // pin values and per-pin masks
  typedef logic [GPIO_W-1:0] gpio_vec_t;
  typedef logic [ADR_W-1:0] bus_adr_t;
  typedef logic [DAT_W-1:0] bus_dat_t;
  typedef logic [PRE_W-1:0] prescale_t;

  ////////////////////
  // register map
  ////////////////////

  // byte offsets, word aligned
  localparam bus_adr_t ADR_OUT = 5'h00;
  localparam bus_adr_t ADR_OEN = 5'h04;
  // read only, filtered pin level
  localparam bus_adr_t ADR_IN = 5'h08;
  localparam bus_adr_t ADR_IRQ_RISE = 5'h0C;
  localparam bus_adr_t ADR_IRQ_FALL = 5'h10;
  // write one to clear
  localparam bus_adr_t ADR_IRQ_STS = 5'h14;
  localparam bus_adr_t ADR_PRESCALE = 5'h18;

endpackage

//--- logic/gpio_sync.sv
// two-flop synchronizer; place directly behind the gpio_i pins before any logic reads them
`timescale 1ns/1ps

module gpio_sync (
  input  logic                tcb,
  input  logic                rst_n,
  // asynchronous pin levels
  input  gpio_pkg::gpio_vec_t gpio_i,
  // pin levels in the tcb domain
  output gpio_pkg::gpio_vec_t pin_sync
);

  import gpio_pkg::*;

  ////////////////////
  // flop chain
  ////////////////////

  // stage 0 catches the pin, last stage is the safe copy
  gpio_vec_t [CDC_STAGES-1:0] sync_q;

  // shift one stage per cycle
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[CDC_STAGES-2:0], gpio_i};
    end
  end

  // CDC_STAGES cycles from pin to output
  assign pin_sync = sync_q[CDC_STAGES-1];

endmodule

//--- logic/gpio_sample_timer.sv
// prescaler for the input filter; strobe pulses once every prescale+1 cycles of tcb
`timescale 1ns/1ps

module gpio_sample_timer (
  input  logic                tcb,
  input  logic                rst_n,
  // sample period minus one
  input  gpio_pkg::prescale_t prescale,
  // one cycle sample enable
  output logic                strobe
);

  import gpio_pkg::*;

  ////////////////////
  // down-counter
  ////////////////////

  // cycles left until the next strobe
  prescale_t cnt;

  // reload at zero
  // new prescale only seen here, so a running period finishes first
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (cnt == '0) begin
      cnt <= prescale;
    end else begin
      cnt <= cnt - prescale_t'(1);
    end
  end

  ////////////////////
  // strobe
  ////////////////////

  // high in the reload cycle
  // prescale of zero keeps it high every cycle
  assign strobe = (cnt == '0);

endmodule

//--- logic/gpio_filter.sv
// glitch filter between synchronizer and register block; a level passes after two equal samples
`timescale 1ns/1ps

module gpio_filter (
  input  logic                tcb,
  input  logic                rst_n,
  // sample enable from the timer
  input  logic                strobe,
  // synchronized pins
  input  gpio_pkg::gpio_vec_t pin_sync,
  // accepted pin levels
  output gpio_pkg::gpio_vec_t pin_filt
);

  import gpio_pkg::*;

  // sample taken at the previous strobe
  gpio_vec_t samp_q;
  // accepted level
  gpio_vec_t filt_q;
  // bits where this sample repeats the last one
  gpio_vec_t agree;

  ////////////////////
  // sampling
  ////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      samp_q <= '0;
    end else if (strobe) begin
      samp_q <= pin_sync;
    end
  end

  ////////////////////
  // acceptance
  ////////////////////

  // compare live sample to the stored one
  assign agree = ~(pin_sync ^ samp_q);

  // agreeing bits take the new level
  // the rest hold, so a pulse under one period never gets through
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      filt_q <= '0;
    end else if (strobe) begin
      filt_q <= (filt_q & ~agree) | (pin_sync & agree);
    end
  end

  assign pin_filt = filt_q;

endmodule

//--- logic/gpio_irq.sv
// edge interrupt block; watches the filtered pins and keeps sticky status for the register block
`timescale 1ns/1ps

module gpio_irq (
  input  logic                tcb,
  input  logic                rst_n,
  // filtered pin levels
  input  gpio_pkg::gpio_vec_t pin_filt,
  // per-bit direction enables
  input  gpio_pkg::gpio_vec_t irq_rise_en,
  input  gpio_pkg::gpio_vec_t irq_fall_en,
  // write one to clear request
  input  logic                sts_clr,
  input  gpio_pkg::gpio_vec_t sts_clr_mask,
  // sticky status and summary line
  output gpio_pkg::gpio_vec_t irq_sts,
  output logic                irq
);

  import gpio_pkg::*;

  // pin_filt one cycle back
  gpio_vec_t pin_dly;
  // enabled edges this cycle
  gpio_vec_t rise_hit;
  gpio_vec_t fall_hit;
  // bits to drop this cycle
  gpio_vec_t clr_bits;
  gpio_vec_t sts_q;

  ////////////////////
  // edge detect
  ////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      pin_dly <= '0;
    end else begin
      pin_dly <= pin_filt;
    end
  end

  // low to high and high to low, masked per direction
  assign rise_hit = pin_filt & ~pin_dly & irq_rise_en;
  assign fall_hit = ~pin_filt & pin_dly & irq_fall_en;

  ////////////////////
  // status
  ////////////////////

  // mask only counts in the write cycle
  assign clr_bits = sts_clr ? sts_clr_mask : '0;

  // clear first, then set, so a new edge beats a clear
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      sts_q <= '0;
    end else begin
      sts_q <= (sts_q & ~clr_bits) | rise_hit | fall_hit;
    end
  end

  assign irq_sts = sts_q;

  // any pending bit
  assign irq = |sts_q;

endmodule

//--- logic/gpio_regs.sv
// bus subordinate of the gpio peripheral; register file, read decode and one-cycle response
`timescale 1ns/1ps

module gpio_regs (
  input  logic                tcb,
  input  logic                rst_n,
  // request, one transfer per cycle with req_vld high
  input  logic                req_vld,
  input  logic                req_wen,
  input  gpio_pkg::bus_adr_t  req_adr,
  input  gpio_pkg::bus_dat_t  req_wdt,
  output logic                req_rdy,
  // response, one cycle after the transfer
  output logic                rsp_vld,
  output gpio_pkg::bus_dat_t  rsp_rdt,
  output logic                rsp_sts,
  // readback sources
  input  gpio_pkg::gpio_vec_t pin_filt,
  input  gpio_pkg::gpio_vec_t irq_sts,
  // pin drivers
  output gpio_pkg::gpio_vec_t gpio_o,
  output gpio_pkg::gpio_vec_t gpio_e,
  // control toward the other blocks
  output gpio_pkg::gpio_vec_t irq_rise_en,
  output gpio_pkg::gpio_vec_t irq_fall_en,
  output gpio_pkg::prescale_t prescale,
  output logic                sts_clr,
  output gpio_pkg::gpio_vec_t sts_clr_mask
);

  import gpio_pkg::*;

  // write transfer this cycle
  logic     wr_en;
  // decoded read data and error flag
  bus_dat_t rdt_d;
  logic     sts_d;

  ////////////////////
  // handshake
  ////////////////////

  // never stalls
  assign req_rdy = 1'b1;

  assign wr_en = req_vld & req_wen;

  ////////////////////
  // write decode
  ////////////////////

  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      gpio_o      <= '0;
      gpio_e      <= '0;
      irq_rise_en <= '0;
      irq_fall_en <= '0;
      prescale    <= '0;
    end else if (wr_en) begin
      case (req_adr)
        ADR_OUT:      gpio_o <= req_wdt;
        ADR_OEN:      gpio_e <= req_wdt;
        ADR_IRQ_RISE: irq_rise_en <= req_wdt;
        ADR_IRQ_FALL: irq_fall_en <= req_wdt;
        // upper half of the word ignored
        ADR_PRESCALE: prescale <= prescale_t'(req_wdt);
        // ADR_IN is read only, status goes through sts_clr
        default: ;
      endcase
    end
  end

  // status clear acts on the same edge as the register writes
  assign sts_clr      = wr_en && (req_adr == ADR_IRQ_STS);
  assign sts_clr_mask = req_wdt;

  ////////////////////
  // read decode
  ////////////////////

  // values before this cycle's write
  always_comb begin
    rdt_d = '0;
    sts_d = 1'b0;
    case (req_adr)
      ADR_OUT:      rdt_d = gpio_o;
      ADR_OEN:      rdt_d = gpio_e;
      ADR_IN:       rdt_d = pin_filt;
      ADR_IRQ_RISE: rdt_d = irq_rise_en;
      ADR_IRQ_FALL: rdt_d = irq_fall_en;
      ADR_IRQ_STS:  rdt_d = irq_sts;
      ADR_PRESCALE: rdt_d = bus_dat_t'(prescale);
      // unmapped, zero data with error
      default:      sts_d = 1'b1;
    endcase
  end

  ////////////////////
  // response stage
  ////////////////////

  // valid follows every transfer by one cycle
  always_ff @(posedge tcb) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= req_vld;
    end
  end

  // data captured on transfers only
  always_ff @(posedge tcb) begin
    if (req_vld) begin
      rsp_rdt <= rdt_d;
      rsp_sts <= sts_d;
    end
  end

endmodule

//--- logic/gpio_subsys.sv
// gpio peripheral top; connect bus, pins and irq here and instantiate this module only
`timescale 1ns/1ps

module gpio_subsys (
  input  logic                tcb,
  input  logic                rst_n,
  // register bus
  input  logic                req_vld,
  input  logic                req_wen,
  input  gpio_pkg::bus_adr_t  req_adr,
  input  gpio_pkg::bus_dat_t  req_wdt,
  output logic                req_rdy,
  output logic                rsp_vld,
  output gpio_pkg::bus_dat_t  rsp_rdt,
  output logic                rsp_sts,
  // pins
  output gpio_pkg::gpio_vec_t gpio_o,
  output gpio_pkg::gpio_vec_t gpio_e,
  input  gpio_pkg::gpio_vec_t gpio_i,
  // level interrupt
  output logic                irq
);

  import gpio_pkg::*;

  ////////////////////
  // internal wires
  ////////////////////

  // input path
  gpio_vec_t pin_sync;
  gpio_vec_t pin_filt;
  logic      strobe;
  prescale_t prescale;

  // interrupt control and readback
  gpio_vec_t irq_rise_en;
  gpio_vec_t irq_fall_en;
  gpio_vec_t irq_sts;
  gpio_vec_t sts_clr_mask;
  logic      sts_clr;

  ////////////////////
  // input path
  ////////////////////

  gpio_sync i_sync (
    .tcb      (tcb),
    .rst_n    (rst_n),
    .gpio_i   (gpio_i),
    .pin_sync (pin_sync)
  );

  gpio_sample_timer i_timer (
    .tcb      (tcb),
    .rst_n    (rst_n),
    .prescale (prescale),
    .strobe   (strobe)
  );

  gpio_filter i_filter (
    .tcb      (tcb),
    .rst_n    (rst_n),
    .strobe   (strobe),
    .pin_sync (pin_sync),
    .pin_filt (pin_filt)
  );

  ////////////////////
  // interrupts
  ////////////////////

  gpio_irq i_irq (
    .tcb          (tcb),
    .rst_n        (rst_n),
    .pin_filt     (pin_filt),
    .irq_rise_en  (irq_rise_en),
    .irq_fall_en  (irq_fall_en),
    .sts_clr      (sts_clr),
    .sts_clr_mask (sts_clr_mask),
    .irq_sts      (irq_sts),
    .irq          (irq)
  );

  ////////////////////
  // registers
  ////////////////////

  gpio_regs i_regs (
    .tcb          (tcb),
    .rst_n        (rst_n),
    .req_vld      (req_vld),
    .req_wen      (req_wen),
    .req_adr      (req_adr),
    .req_wdt      (req_wdt),
    .req_rdy      (req_rdy),
    .rsp_vld      (rsp_vld),
    .rsp_rdt      (rsp_rdt),
    .rsp_sts      (rsp_sts),
    .pin_filt     (pin_filt),
    .irq_sts      (irq_sts),
    .gpio_o       (gpio_o),
    .gpio_e       (gpio_e),
    .irq_rise_en  (irq_rise_en),
    .irq_fall_en  (irq_fall_en),
    .prescale     (prescale),
    .sts_clr      (sts_clr),
    .sts_clr_mask (sts_clr_mask)
  );

endmodule

//--- verification/gpio_subsys_tb.sv
// self-checking testbench that the file list builds with gpio_subsys_tb as top module
`timescale 1ns/1ps

module gpio_subsys_tb;

  import gpio_pkg::*;

  ////////////////////
  // run length
  ////////////////////

  localparam int CLK_PERIOD = 100;
  // input settling at prescale 0 and 15
  localparam int SETTLE_FAST = CDC_STAGES + 2 * 1 + 2;
  localparam int SETTLE_SLOW = CDC_STAGES + 2 * 16 + 2;
  // reset and the tests in order
  localparam int TEST_CYCLES = 8 + 90 + 25 + 4 * (SETTLE_FAST + 8)
                             + 16 * (SETTLE_SLOW + 10) + 3 * (SETTLE_SLOW + 10) + 25;
  localparam int MARGIN_CYCLES = 200;

  logic      tcb;
  logic      rst_n;
  logic      req_vld;
  logic      req_wen;
  bus_adr_t  req_adr;
  bus_dat_t  req_wdt;
  logic      req_rdy;
  logic      rsp_vld;
  bus_dat_t  rsp_rdt;
  logic      rsp_sts;
  gpio_vec_t gpio_o;
  gpio_vec_t gpio_e;
  gpio_vec_t gpio_i;
  logic      irq;

  // register model
  gpio_vec_t m_out;
  gpio_vec_t m_oen;
  gpio_vec_t m_rise;
  gpio_vec_t m_fall;
  gpio_vec_t m_in;
  gpio_vec_t m_sts;
  prescale_t m_pre;

  // expected responses with the oldest first
  bus_dat_t  exp_rdt_q[$];
  logic      exp_sts_q[$];
  logic      exp_rd_q[$];
  gpio_vec_t exp_o_q[$];
  gpio_vec_t exp_e_q[$];

  logic   vld_prev;
  int     chk_cnt;
  int     err_cnt;
  integer seed = 32'h6e186baa;

  gpio_subsys i_dut (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req_wen (req_wen),
    .req_adr (req_adr),
    .req_wdt (req_wdt),
    .req_rdy (req_rdy),
    .rsp_vld (rsp_vld),
    .rsp_rdt (rsp_rdt),
    .rsp_sts (rsp_sts),
    .gpio_o  (gpio_o),
    .gpio_e  (gpio_e),
    .gpio_i  (gpio_i),
    .irq     (irq)
  );

  always #(CLK_PERIOD / 2) tcb = ~tcb;

  ////////////////////
  // reference model
  ////////////////////

  // {sts, data} the register map gives for a read at adr
  function automatic logic [DAT_W:0] ref_read(input bus_adr_t adr);
    logic [DAT_W:0] rsp;
    case (adr)
      ADR_OUT:      rsp = {1'b0, m_out};
      ADR_OEN:      rsp = {1'b0, m_oen};
      ADR_IN:       rsp = {1'b0, m_in};
      ADR_IRQ_RISE: rsp = {1'b0, m_rise};
      ADR_IRQ_FALL: rsp = {1'b0, m_fall};
      ADR_IRQ_STS:  rsp = {1'b0, m_sts};
      ADR_PRESCALE: rsp = {1'b0, bus_dat_t'(m_pre)};
      default:      rsp = {1'b1, bus_dat_t'(0)};
    endcase
    return rsp;
  endfunction

  task automatic model_write(input bus_adr_t adr, input bus_dat_t wdt);
    case (adr)
      ADR_OUT:      m_out = wdt;
      ADR_OEN:      m_oen = wdt;
      ADR_IRQ_RISE: m_rise = wdt;
      ADR_IRQ_FALL: m_fall = wdt;
      ADR_IRQ_STS:  m_sts = m_sts & ~wdt;
      ADR_PRESCALE: m_pre = prescale_t'(wdt);
      default: ;
    endcase
  endtask

  function automatic int settle_cycles(input prescale_t pre);
    return CDC_STAGES + 2 * (int'(pre) + 1) + 2;
  endfunction

  ////////////////////
  // stimulus helpers
  ////////////////////

  // one transfer with its expected response queued at issue
  task automatic bus_xfer(input logic wen, input bus_adr_t adr, input bus_dat_t wdt);
    logic [DAT_W:0] rsp;
    @(posedge tcb);
    rsp = ref_read(adr);
    req_vld <= 1'b1;
    req_wen <= wen;
    req_adr <= adr;
    req_wdt <= wdt;
    exp_rdt_q.push_back(rsp[DAT_W-1:0]);
    exp_sts_q.push_back(rsp[DAT_W]);
    exp_rd_q.push_back(!wen);
    if (wen) begin
      model_write(adr, wdt);
    end
    // pins after this write
    exp_o_q.push_back(m_out);
    exp_e_q.push_back(m_oen);
  endtask

  task automatic bus_idle();
    @(posedge tcb);
    req_vld <= 1'b0;
    req_wen <= 1'b0;
  endtask

  // new pin level held until filtered and its edges added to the status model
  task automatic settle_pins(input gpio_vec_t val);
    @(posedge tcb);
    gpio_i <= val;
    repeat (settle_cycles(m_pre)) @(posedge tcb);
    m_sts = m_sts | (val & ~m_in & m_rise) | (~val & m_in & m_fall);
    m_in = val;
  endtask

  // one cycle pulse on mask bits before returning to the stable level
  task automatic pin_glitch(input gpio_vec_t mask);
    @(posedge tcb);
    gpio_i <= m_in ^ mask;
    @(posedge tcb);
    gpio_i <= m_in;
    repeat (settle_cycles(m_pre)) @(posedge tcb);
  endtask

  task automatic report_mismatch(input string name, input bus_dat_t got, input bus_dat_t exp);
    err_cnt++;
    $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
  endtask

  task automatic check_irq();
    @(negedge tcb);
    chk_cnt++;
    if (irq !== (|m_sts)) report_mismatch("irq", bus_dat_t'(irq), bus_dat_t'(|m_sts));
  endtask

  ////////////////////
  // comparator
  ////////////////////

  // outputs are stable at the falling edge
  always @(negedge tcb) begin : compare
    bus_dat_t  e_rdt;
    logic      e_sts;
    logic      e_rd;
    gpio_vec_t e_o;
    gpio_vec_t e_e;
    if (rst_n) begin
      // subordinate never stalls
      if (req_rdy !== 1'b1) report_mismatch("req_rdy", bus_dat_t'(req_rdy), bus_dat_t'(1'b1));
      if (rsp_vld && !vld_prev) begin
        err_cnt++;
        $display("error at %0t: response without a transfer one cycle before", $time);
      end else if (!rsp_vld && vld_prev) begin
        err_cnt++;
        $display("error at %0t: transfer got no response one cycle later", $time);
      end
      if (rsp_vld && exp_rdt_q.size() == 0) begin
        err_cnt++;
        $display("error at %0t: response with nothing expected", $time);
      end else if (rsp_vld) begin
        e_rdt = exp_rdt_q.pop_front();
        e_sts = exp_sts_q.pop_front();
        e_rd  = exp_rd_q.pop_front();
        e_o   = exp_o_q.pop_front();
        e_e   = exp_e_q.pop_front();
        chk_cnt++;
        // write responses carry no defined data
        if (e_rd && rsp_rdt !== e_rdt) report_mismatch("rsp_rdt", rsp_rdt, e_rdt);
        if (rsp_sts !== e_sts) report_mismatch("rsp_sts", bus_dat_t'(rsp_sts), bus_dat_t'(e_sts));
        if (gpio_o !== e_o) report_mismatch("gpio_o", gpio_o, e_o);
        if (gpio_e !== e_e) report_mismatch("gpio_e", gpio_e, e_e);
      end
    end
    vld_prev = req_vld;
  end

  ////////////////////
  // watchdog
  ////////////////////

  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////
  // test sequence
  ////////////////////

  initial begin : stimulus
    int        i;
    gpio_vec_t val;
    tcb      = 1'b0;
    rst_n    = 1'b0;
    req_vld  = 1'b0;
    req_wen  = 1'b0;
    req_adr  = '0;
    req_wdt  = '0;
    gpio_i   = '0;
    vld_prev = 1'b0;
    chk_cnt  = 0;
    err_cnt  = 0;
    {m_out, m_oen, m_rise, m_fall, m_in, m_sts} = '0;
    m_pre    = '0;
    repeat (8) @(posedge tcb);
    rst_n <= 1'b1;
    repeat (2) @(posedge tcb);

    // output and enable registers written and read back to back
    for (i = 0; i < 20; i++) begin
      bus_xfer(1'b1, ADR_OUT, $random(seed));
      bus_xfer(1'b1, ADR_OEN, $random(seed));
      bus_xfer(1'b0, ADR_OUT, '0);
      bus_xfer(1'b0, ADR_OEN, '0);
    end

    // unmapped offsets and the read only input register
    bus_xfer(1'b1, 5'h1C, $random(seed));
    bus_xfer(1'b1, 5'h02, $random(seed));
    bus_xfer(1'b1, ADR_IN, $random(seed));
    bus_xfer(1'b0, 5'h1C, '0);
    bus_xfer(1'b0, 5'h0D, '0);
    bus_xfer(1'b0, ADR_OUT, '0);
    bus_xfer(1'b0, ADR_OEN, '0);
    bus_xfer(1'b0, ADR_IN, '0);
    bus_xfer(1'b0, ADR_IRQ_RISE, '0);
    bus_xfer(1'b0, ADR_IRQ_FALL, '0);
    bus_xfer(1'b0, ADR_IRQ_STS, '0);
    bus_xfer(1'b0, ADR_PRESCALE, '0);
    bus_idle();

    // random input level reaches ADR_IN
    for (i = 0; i < 4; i++) begin
      settle_pins($random(seed));
      bus_xfer(1'b0, ADR_IN, '0);
      bus_idle();
    end

    // glitches at prescale 15 with both directions enabled
    bus_xfer(1'b1, ADR_IRQ_RISE, '1);
    bus_xfer(1'b1, ADR_IRQ_FALL, '1);
    bus_xfer(1'b1, ADR_PRESCALE, 32'd15);
    bus_idle();
    // 41 cycle passes walk the glitch across all 16 strobe phases
    for (i = 0; i < 16; i++) begin
      pin_glitch($random(seed));
      bus_xfer(1'b0, ADR_IN, '0);
      bus_xfer(1'b0, ADR_IRQ_STS, '0);
      bus_idle();
      check_irq();
    end

    // edge interrupts with mixed direction enables
    bus_xfer(1'b1, ADR_IRQ_RISE, $random(seed));
    bus_xfer(1'b1, ADR_IRQ_FALL, $random(seed));
    bus_idle();
    for (i = 0; i < 3; i++) begin
      val = $random(seed);
      settle_pins(m_in ^ val);
      bus_xfer(1'b0, ADR_IRQ_STS, '0);
      bus_xfer(1'b0, ADR_IN, '0);
      bus_idle();
      check_irq();
    end

    // write one to clear with a partial mask and then a full one
    val = $random(seed);
    bus_xfer(1'b1, ADR_IRQ_STS, m_sts & val);
    bus_xfer(1'b0, ADR_IRQ_STS, '0);
    bus_idle();
    check_irq();
    bus_xfer(1'b1, ADR_IRQ_STS, '1);
    bus_xfer(1'b0, ADR_IRQ_STS, '0);
    bus_idle();
    check_irq();

    repeat (4) @(posedge tcb);
    if (exp_rdt_q.size() != 0) begin
      err_cnt++;
      $display("%0d expected responses never arrived", exp_rdt_q.size());
    end
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- gpio_subsys.f
logic/gpio_pkg.sv
logic/gpio_sync.sv
logic/gpio_sample_timer.sv
logic/gpio_filter.sv
logic/gpio_irq.sv
logic/gpio_regs.sv
logic/gpio_subsys.sv
verification/gpio_subsys_tb.sv

//--- run.sh
#!/bin/sh
# build the gpio testbench with Verilator, run it, and exit non-zero on failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_gpio

verilator --binary --timing -j 0 \
  --top-module gpio_subsys_tb \
  -f gpio_subsys.f \
  -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
exit 0
